// ==== Makefile ====
# Verilator build and run of the CFT control unit testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= cft_cpu_tb
FILELIST ?= cft_cpu.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/cft_cpu_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Instruction-level reference of the CFT control unit, with the program
// image helpers. Included inside the testbench module body, after the
// package import; fills the expected write list and the final memory.
////////////////////////////////////////////////////////////////////////////

`ifndef CFT_CPU_MODEL_SVH
`define CFT_CPU_MODEL_SVH

`include "cft_cpu_cfg.svh"

// Program image, and the memory the reference leaves behind
word_t image_mem [0:65535];
word_t model_mem [0:65535];

// Expected writes in issue order
word_t exp_addr [$];
word_t exp_data [$];

// Background pattern, a different word for every address
function automatic word_t fill_word(input int addr);
   return word_t'(addr * 40503) ^ word_t'(addr >> 7) ^ 16'h5A5A;
endfunction

function automatic void clear_image();
   for (int a = 0; a < 65536; a++) begin
      image_mem[a] = fill_word(a);
   end
endfunction

// Opcode, I, R and a 10-bit offset (OP1 takes its bits in the offset)
function automatic word_t instr_word(input opcode_e op, input logic ind,
                                     input logic rpage, input int offset);
   word_t w;
   w                             = '0;
   w[`CFT_OP_HI:`CFT_OP_LO]      = op;
   w[`CFT_I_BIT]                 = ind;
   w[`CFT_R_BIT]                 = rpage;
   w[`CFT_OFFSET_W-1:0]          = offset[`CFT_OFFSET_W-1:0];
   return w;
endfunction

function automatic void store_expected(input word_t addr, input word_t data);
   model_mem[addr] = data;
   exp_addr.push_back(addr);
   exp_data.push_back(data);
endfunction

// Runs the image from the reset PC; returns the instruction count up to
// and including TRAP, or -1 when the limit runs out first
function automatic int run_model(input int max_instr);
   word_t      pc;
   word_t      acc;
   word_t      ir;
   word_t      ea;
   logic [3:0] op;
   int         count;
   pc        = word_t'(`CFT_RESET_PC);
   acc       = '0;
   count     = 0;
   model_mem = image_mem;
   exp_addr.delete();
   exp_data.delete();
   while (count < max_instr) begin
      ir    = model_mem[pc];
      pc    = pc + 1'b1;
      count = count + 1;
      op    = ir[`CFT_OP_HI:`CFT_OP_LO];
      // Current page is taken after the fetch increment
      if (ir[`CFT_R_BIT]) begin
         ea = {pc[`CFT_WORD_W-1:`CFT_OFFSET_W], ir[`CFT_OFFSET_W-1:0]};
      end else begin
         ea = word_t'(ir[`CFT_OFFSET_W-1:0]);
      end
      if (ir[`CFT_I_BIT] && (op inside {OP_LOAD, OP_STOR, OP_JMP, OP_JSR})) begin
         // Autoindex pointer is bumped and written back before use
         if (ea >= `CFT_AUTOINDEX_LO && ea <= `CFT_AUTOINDEX_HI) begin
            store_expected(ea, model_mem[ea] + 1'b1);
         end
         ea = model_mem[ea];
      end
      case (op)
         OP_TRAP: return count;
         OP_LOAD: acc = model_mem[ea];
         OP_STOR: store_expected(ea, acc);
         OP_JMP:  pc = ea;
         OP_JSR: begin
            store_expected(ea, pc);
            pc = ea + 1'b1;
         end
         OP_OP1: begin
            // Clear, then increment, then the skip test on the new A
            if (ir[0]) begin
               acc = '0;
            end
            if (ir[1]) begin
               acc = acc + 1'b1;
            end
            if ((ir[2] && acc == '0) || (ir[3] && acc[`CFT_WORD_W-1])) begin
               pc = pc + 1'b1;
            end
         end
         default: ;
      endcase
   end
   return -1;
endfunction

`endif

// ==== bench/cft_cpu_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench of the CFT control unit. Runs directed and random programs
// from a 64-kword memory, checks each write against the reference, then
// the final memory, the write count and the quiet state after halt.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_cpu_cfg.svh"

module cft_cpu_tb;
   import cft_cpu_pkg::*;

   logic  clock;
   logic  reset;
   word_t mem_rdata;
   word_t mem_addr;
   word_t mem_wdata;
   logic  mem_read;
   logic  mem_write;
   logic  halt;

   // Memory seen by the DUT
   word_t ram [0:65535];

   string test_name;
   int    errors;
   int    checks;
   int    wr_count;
   // Reset as sampled at the last rising edge
   logic  in_reset;
   logic  first_read_pending;

   `include "cft_cpu_model.svh"

   cft_cpu UUT (
      .clock     (clock),
      .reset     (reset),
      .mem_rdata (mem_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_read  (mem_read),
      .mem_write (mem_write),
      .halt      (halt)
   );

   // Read data answers the MAR combinationally
   assign mem_rdata = $isunknown(mem_addr) ? '0 : ram[mem_addr];

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   always @(posedge clock) begin
      in_reset <= reset;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Comparison process
   ////////////////////////////////////////////////////////////////////////////

   // Strobes are settled at the falling edge, memory stores there as well
   always @(negedge clock) begin
      if (in_reset) begin
         first_read_pending = 1'b1;
         if (mem_read === 1'b1 || mem_write === 1'b1 || halt === 1'b1) begin
            errors++;
            $display("%s: strobe or halt seen while in reset", test_name);
         end
      end else begin
         if (mem_read && first_read_pending) begin
            checks++;
            first_read_pending = 1'b0;
            if (mem_addr !== word_t'(`CFT_RESET_PC)) begin
               errors++;
               $display("mismatch %s: first fetch address expected %h actual %h",
                        test_name, word_t'(`CFT_RESET_PC), mem_addr);
            end
         end
         if (halt && (mem_read || mem_write)) begin
            errors++;
            $display("%s: memory strobe after halt", test_name);
         end
         if (mem_write) begin
            checks++;
            if (wr_count >= exp_addr.size()) begin
               errors++;
               $display("%s: write to %h beyond the %0d expected writes",
                        test_name, mem_addr, exp_addr.size());
            end else begin
               if (mem_addr !== exp_addr[wr_count]) begin
                  errors++;
                  $display("mismatch %s: write %0d address expected %h actual %h",
                           test_name, wr_count, exp_addr[wr_count], mem_addr);
               end
               if (mem_wdata !== exp_data[wr_count]) begin
                  errors++;
                  $display("mismatch %s: write %0d data expected %h actual %h",
                           test_name, wr_count, exp_data[wr_count], mem_wdata);
               end
            end
            wr_count++;
            ram[mem_addr] = mem_wdata;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test runner
   ////////////////////////////////////////////////////////////////////////////

   // Reset, load the image, run until halt, then compare the memory
   task automatic run_test(input string name);
      int instr;
      int limit;
      int cycles;
      int bad;
      test_name = name;
      @(posedge clock);
      #1 reset = 1'b1;
      repeat (8) @(posedge clock);
      ram   = image_mem;
      instr = run_model(4000);
      if (instr < 0) begin
         errors++;
         $display("%s: reference model never reached TRAP", name);
         return;
      end
      wr_count = 0;
      limit    = 12 * instr + 100;
      cycles   = 0;
      #1 reset = 1'b0;
      while (halt !== 1'b1) begin
         @(negedge clock);
         cycles++;
         if (cycles > limit) begin
            errors++;
            $display("%s: no halt within %0d cycles", name, limit);
            $display("errors: %0d, checks: %0d", errors, checks);
            $display("Verification failed");
            $finish;
         end
      end
      // Quiet period after halt
      repeat (20) @(negedge clock);
      checks++;
      if (wr_count != exp_addr.size()) begin
         errors++;
         $display("mismatch %s: write count expected %0d actual %0d",
                  name, exp_addr.size(), wr_count);
      end
      bad = 0;
      for (int a = 0; a < 65536; a++) begin
         if (ram[a] !== model_mem[a]) begin
            errors++;
            bad++;
            if (bad <= 8) begin
               $display("mismatch %s: memory %h expected %h actual %h",
                        name, a[15:0], model_mem[a], ram[a]);
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Programs
   ////////////////////////////////////////////////////////////////////////////

   // Code on page 3 mixes page zero and current page operands
   task automatic page_test();
      clear_image();
      image_mem['h0000] = instr_word(OP_JMP, 1'b1, 1'b0, 'h020);
      image_mem['h0020] = 16'h0C00;
      image_mem['h0C00] = instr_word(OP_LOAD, 1'b0, 1'b1, 'h050);
      image_mem['h0C01] = instr_word(OP_STOR, 1'b0, 1'b0, 'h060);
      image_mem['h0C02] = instr_word(OP_LOAD, 1'b0, 1'b0, 'h061);
      image_mem['h0C03] = instr_word(OP_STOR, 1'b0, 1'b1, 'h051);
      image_mem['h0C04] = instr_word(OP_TRAP, 1'b0, 1'b0, 0);
      image_mem['h0C50] = 16'h1234;
      image_mem['h0061] = 16'hBEEF;
      run_test("load_store_pages");
   endtask

   // Pointers at 127, 128, 133, 255 and 256, plus one far below
   task automatic indirect_test();
      clear_image();
      image_mem[0]      = instr_word(OP_LOAD, 1'b1, 1'b0, 'h085);
      image_mem[1]      = instr_word(OP_STOR, 1'b1, 1'b0, 'h085);
      image_mem[2]      = instr_word(OP_LOAD, 1'b1, 1'b0, 'h040);
      image_mem[3]      = instr_word(OP_STOR, 1'b1, 1'b0, 'h100);
      image_mem[4]      = instr_word(OP_STOR, 1'b1, 1'b0, 'h0FF);
      image_mem[5]      = instr_word(OP_LOAD, 1'b1, 1'b1, 'h080);
      image_mem[6]      = instr_word(OP_STOR, 1'b1, 1'b0, 'h07F);
      image_mem[7]      = instr_word(OP_TRAP, 1'b0, 1'b0, 0);
      image_mem['h085]  = 16'h0300;
      image_mem['h040]  = 16'h0310;
      image_mem['h100]  = 16'h0320;
      image_mem['h0FF]  = 16'h0330;
      image_mem['h080]  = 16'h033F;
      image_mem['h07F]  = 16'h0350;
      run_test("indirect_autoindex");
   endtask

   // Direct and autoindexed JSR, then an indirect JMP to page 2
   task automatic jump_test();
      clear_image();
      image_mem['h000] = instr_word(OP_JMP, 1'b0, 1'b0, 'h010);
      image_mem['h010] = instr_word(OP_JSR, 1'b0, 1'b0, 'h030);
      image_mem['h031] = instr_word(OP_JSR, 1'b1, 1'b0, 'h090);
      image_mem['h090] = 16'h004F;
      image_mem['h051] = instr_word(OP_JMP, 1'b1, 1'b0, 'h042);
      image_mem['h042] = 16'h0800;
      image_mem['h800] = instr_word(OP_JSR, 1'b0, 1'b1, 'h100);
      image_mem['h901] = instr_word(OP_TRAP, 1'b0, 1'b0, 0);
      run_test("jmp_jsr");
   endtask

   // A values weighted toward the skip corners
   function automatic word_t random_operand();
      case ($urandom % 4)
         0:       return '0;
         1:       return 16'hFFFF;
         2:       return 16'h8000;
         default: return word_t'($urandom);
      endcase
   endfunction

   // LOAD, OP1, then a STOR that may be skipped and one that never is
   task automatic op1_test();
      int base;
      clear_image();
      for (int k = 0; k < 20; k++) begin
         base                  = 4 * k;
         image_mem[base]       = instr_word(OP_LOAD, 1'b0, 1'b0, 'h200 + k);
         image_mem[base + 1]   = instr_word(OP_OP1, 1'b0, 1'b0, $urandom % 16);
         image_mem[base + 2]   = instr_word(OP_STOR, 1'b0, 1'b0, 'h240 + k);
         image_mem[base + 3]   = instr_word(OP_STOR, 1'b0, 1'b0, 'h280 + k);
         image_mem['h200 + k]  = random_operand();
      end
      image_mem[80] = instr_word(OP_TRAP, 1'b0, 1'b0, 0);
      run_test("op1_random");
   endtask

   // Forward jumps and skips only, so every program reaches a TRAP
   task automatic random_program_test(input int n);
      int   kind;
      int   off;
      logic rpage;
      clear_image();
      for (int p = 0; p < 40; p++) begin
         kind  = $urandom % 4;
         off   = 'h200 + ($urandom % 64);
         rpage = ($urandom % 2) == 1;
         case (kind)
            0: image_mem[p] = instr_word(OP_LOAD, 1'b0, rpage, off);
            1: image_mem[p] = instr_word(OP_STOR, 1'b0, rpage, off);
            2: image_mem[p] = instr_word(OP_OP1, 1'b0, 1'b0, $urandom % 16);
            default: image_mem[p] = instr_word(OP_JMP, 1'b0, 1'b0,
                                               p + 1 + ($urandom % (40 - p)));
         endcase
      end
      for (int p = 40; p < 43; p++) begin
         image_mem[p] = instr_word(OP_TRAP, 1'b0, 1'b0, 0);
      end
      for (int d = 0; d < 64; d++) begin
         image_mem['h200 + d] = random_operand();
      end
      run_test($sformatf("random_program_%0d", n));
   endtask

   initial begin
      reset              = 1'b1;
      errors             = 0;
      checks             = 0;
      wr_count           = 0;
      first_read_pending = 1'b0;
      test_name          = "startup";
      void'($urandom(4));
      page_test();
      indirect_test();
      jump_test();
      op1_test();
      for (int n = 0; n < 4; n++) begin
         random_program_test(n);
      end
      $display("errors: %0d, checks: %0d", errors, checks);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== cft_cpu.f ====
+incdir+hdl
+incdir+bench
hdl/cft_cpu_pkg.sv
hdl/unit_sel_if.sv
hdl/microcode_rom.sv
hdl/micro_sequencer.sv
hdl/unit_decoder.sv
hdl/skip_unit.sv
hdl/cpu_datapath.sv
hdl/cft_cpu.sv
bench/cft_cpu_tb.sv

// ==== hdl/cft_cpu.sv ====
////////////////////////////////////////////////////////////////////////////
// Top of the CFT microcoded control unit. Connects the sequencer, unit
// decoder, skip unit and datapath to a single-cycle strobed memory.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cft_cpu (
   input  logic                clock,
   input  logic                reset,
   input  cft_cpu_pkg::word_t  mem_rdata,
   output cft_cpu_pkg::word_t  mem_addr,
   output cft_cpu_pkg::word_t  mem_wdata,
   output logic                mem_read,
   output logic                mem_write,
   output logic                halt
);
   import cft_cpu_pkg::*;

   // Datapath state seen by control
   word_t  ir;
   word_t  acc;

   // Current microinstruction and registered skip bit
   ucode_t uinst;
   logic   skip;

   unit_sel_if sel_if ();

   // Sequencer addresses the microcode from IR, skip and MAR
   micro_sequencer u_seq (
      .clock (clock),
      .reset (reset),
      .ir    (ir),
      .mar   (mem_addr),
      .skip  (skip),
      .uinst (uinst),
      .halt  (halt)
   );

   unit_decoder u_dec (
      .uinst     (uinst),
      .sel       (sel_if.decoder),
      .mem_read  (mem_read),
      .mem_write (mem_write)
   );

   skip_unit u_skip (
      .clock (clock),
      .reset (reset),
      .uinst (uinst),
      .ir    (ir),
      .acc   (acc),
      .skip  (skip)
   );

   // MAR is the memory address, the internal bus is the write data
   cpu_datapath u_dp (
      .clock     (clock),
      .reset     (reset),
      .sel       (sel_if.datapath),
      .mem_rdata (mem_rdata),
      .bus       (mem_wdata),
      .ir        (ir),
      .acc       (acc),
      .mar       (mem_addr)
   );

endmodule

// ==== hdl/cft_cpu_cfg.svh ====
////////////////////////////////////////////////////////////////////////////
// Build-time constants of the CFT control unit: word width, instruction
// field positions, microaddress layout, autoindex window and reset PC.
// Included by the package and by every module that needs the numbers.
////////////////////////////////////////////////////////////////////////////

`ifndef CFT_CPU_CFG_SVH
`define CFT_CPU_CFG_SVH

// Data and address width
`define CFT_WORD_W 16

// Instruction fields
`define CFT_OP_HI 15
`define CFT_OP_LO 12
`define CFT_I_BIT 11
`define CFT_R_BIT 10
`define CFT_OFFSET_W 10

// Microprogram counter, and the full microaddress
// (opcode, I, skip, autoindex, counter)
`define CFT_UPC_W 4
`define CFT_UADDR_W (`CFT_UPC_W + 7)

// Autoindex window on page zero
`define CFT_AUTOINDEX_LO 128
`define CFT_AUTOINDEX_HI 255

`define CFT_RESET_PC 0

`endif

// ==== hdl/cft_cpu_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types shared by the CFT control unit: machine word, opcodes, bus source
// and destination codes, skip control and the microinstruction word.
////////////////////////////////////////////////////////////////////////////

`include "cft_cpu_cfg.svh"

package cft_cpu_pkg;

   typedef logic [`CFT_WORD_W-1:0] word_t;

   // Kept opcodes; everything else executes as a no-op
   typedef enum logic [3:0] {
      OP_TRAP = 4'd0,
      OP_LOAD = 4'd2,
      OP_STOR = 4'd3,
      OP_JMP  = 4'd6,
      OP_JSR  = 4'd7,
      OP_OP1  = 4'd12
   } opcode_e;

   // Unit driving the internal bus
   typedef enum logic [2:0] {
      RD_NONE, RD_MEM, RD_AGL, RD_PC, RD_DR, RD_A, RD_MAR, RD_ZERO
   } read_unit_e;

   // Unit latching the internal bus
   typedef enum logic [2:0] {
      WR_NONE, WR_MEM, WR_MAR, WR_PC, WR_IR, WR_DR, WR_A
   } write_unit_e;

   // Load source of the skip flip-flop
   typedef enum logic [1:0] {
      SK_HOLD, SK_IRBIT0, SK_IRBIT1, SK_FLAGS
   } skip_ctl_e;

   // One microinstruction, 16 bits; all zero is an idle step
   typedef struct packed {
      read_unit_e  read_unit;
      write_unit_e write_unit;
      skip_ctl_e   skip_ctl;
      logic        inc_a;
      logic        inc_pc;
      logic        inc_dr;
      logic        halt;
      logic        iend;      // Back to fetch after this step
      logic [2:0]  spare;
   } ucode_t;

endpackage

// ==== hdl/cpu_datapath.sv ====
////////////////////////////////////////////////////////////////////////////
// Register datapath: PC, A, IR, DR and MAR around one internal bus.
// Address generation joins the page and the offset; the bus is a
// multiplexer steered by the decoded read selects.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_cpu_cfg.svh"

module cpu_datapath (
   input  logic               clock,
   input  logic               reset,
   unit_sel_if.datapath       sel,
   input  cft_cpu_pkg::word_t mem_rdata,
   output cft_cpu_pkg::word_t bus,
   output cft_cpu_pkg::word_t ir,
   output cft_cpu_pkg::word_t acc,
   output cft_cpu_pkg::word_t mar
);
   import cft_cpu_pkg::*;

   word_t pc;
   word_t dr;
   word_t agl;

   ////////////////////////////////////////////////////////////////////////////
   // Address generation
   ////////////////////////////////////////////////////////////////////////////

   // R set gives the current page, R clear gives page zero
   always_comb begin
      if (ir[`CFT_R_BIT]) begin
         agl = {pc[`CFT_WORD_W-1:`CFT_OFFSET_W], ir[`CFT_OFFSET_W-1:0]};
      end else begin
         agl = {{(`CFT_WORD_W-`CFT_OFFSET_W){1'b0}}, ir[`CFT_OFFSET_W-1:0]};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Internal bus
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      unique case (1'b1)
         sel.r_mem:  bus = mem_rdata;
         sel.r_agl:  bus = agl;
         sel.r_pc:   bus = pc;
         sel.r_dr:   bus = dr;
         sel.r_a:    bus = acc;
         sel.r_mar:  bus = mar;
         sel.r_zero: bus = '0;
         default:    bus = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////////////////////

   // PC and A, cleared by reset; a load wins over an increment
   always_ff @(posedge clock) begin
      if (reset) begin
         pc  <= `CFT_WORD_W'(`CFT_RESET_PC);
         acc <= '0;
      end else begin
         if (sel.w_pc) begin
            pc <= bus;
         end else if (sel.inc_pc) begin
            pc <= pc + 1'b1;
         end
         if (sel.w_a) begin
            acc <= bus;
         end else if (sel.inc_a) begin
            acc <= acc + 1'b1;
         end
      end
   end

   // IR, DR and MAR
   always_ff @(posedge clock) begin
      if (sel.w_ir) begin
         ir <= bus;
      end
      if (sel.w_mar) begin
         mar <= bus;
      end
      // Pointer and link scratch register
      if (sel.w_dr) begin
         dr <= bus;
      end else if (sel.inc_dr) begin
         dr <= dr + 1'b1;
      end
   end

   // Registers only load from a driven bus
   a_load_has_source : assert property (
      @(posedge clock) disable iff (reset)
      (sel.w_mar || sel.w_pc || sel.w_ir || sel.w_dr || sel.w_a) |->
         (sel.r_mem || sel.r_agl || sel.r_pc || sel.r_dr || sel.r_a || sel.r_mar || sel.r_zero)
   ) else $error("register load with no unit driving the internal bus");

endmodule

// ==== hdl/micro_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Microsequencer: steps the microprogram counter, assembles the
// microaddress and latches halt. Once halted it issues idle steps only,
// until reset.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_cpu_cfg.svh"

module micro_sequencer (
   input  logic                clock,
   input  logic                reset,
   input  cft_cpu_pkg::word_t  ir,
   input  cft_cpu_pkg::word_t  mar,
   input  logic                skip,
   output cft_cpu_pkg::ucode_t uinst,
   output logic                halt
);
   import cft_cpu_pkg::*;

   logic [`CFT_UPC_W-1:0]   upc;
   logic [`CFT_UADDR_W-1:0] uaddr;
   logic                    autoindex;
   ucode_t                  rom_uinst;

   ////////////////////////////////////////////////////////////////////////////
   // Microaddress
   ////////////////////////////////////////////////////////////////////////////

   // MAR inside the autoindex window on page zero
   assign autoindex = (mar >= `CFT_WORD_W'(`CFT_AUTOINDEX_LO)) &&
                      (mar <= `CFT_WORD_W'(`CFT_AUTOINDEX_HI));

   // Opcode, indirect flag, skip, autoindex, step
   assign uaddr = {ir[`CFT_OP_HI:`CFT_OP_LO], ir[`CFT_I_BIT], skip, autoindex, upc};

   microcode_rom u_rom (
      .uaddr (uaddr),
      .uinst (rom_uinst)
   );

   // Halted core sees an all-idle microinstruction
   assign uinst = halt ? ucode_t'('0) : rom_uinst;

   ////////////////////////////////////////////////////////////////////////////
   // Counter and halt latch
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         upc  <= '0;
         halt <= 1'b0;
      end else if (!halt) begin
         // End step restarts at fetch
         if (rom_uinst.iend) begin
            upc <= '0;
         end else begin
            upc <= upc + 1'b1;
         end
         if (rom_uinst.halt) begin
            halt <= 1'b1;
         end
      end
   end

   // Every microprogram ends before the counter runs out
   a_upc_no_wrap : assert property (
      @(posedge clock) disable iff (reset)
      (!halt && upc == '1) |-> rom_uinst.iend
   ) else $error("microprogram counter wraps without an end step");

endmodule

// ==== hdl/microcode_rom.sv ====
////////////////////////////////////////////////////////////////////////////
// Microcode table. Combinational, indexed by {opcode, I, skip, autoindex,
// step}. Steps 0 and 1 fetch, execution starts at step 2.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_cpu_cfg.svh"

module microcode_rom (
   input  logic [`CFT_UADDR_W-1:0] uaddr,
   output cft_cpu_pkg::ucode_t     uinst
);
   import cft_cpu_pkg::*;

   logic [3:0]            op_raw;
   opcode_e               op;
   logic                  ind;
   logic                  sk;
   logic                  ai;
   logic [`CFT_UPC_W-1:0] step;
   // Step loading MAR (or PC) with the effective address
   logic [`CFT_UPC_W-1:0] ea_step;
   read_unit_e            ea_src;

   assign {op_raw, ind, sk, ai, step} = uaddr;
   assign op = opcode_e'(op_raw);

   // Indirect EA comes out of DR after the pointer steps
   assign ea_step = ind ? `CFT_UPC_W'(6) : `CFT_UPC_W'(2);
   assign ea_src  = ind ? RD_DR : RD_AGL;

   // Plain bus transfer, nothing else
   function automatic ucode_t xfer(input read_unit_e src, input write_unit_e dst);
      ucode_t u;
      u            = '0;
      u.read_unit  = src;
      u.write_unit = dst;
      return u;
   endfunction

   // Pointer fetch for indirect modes, steps 2 to 5
   // autoindex pre-increments the pointer and writes it back
   function automatic ucode_t ptr_row(input logic [`CFT_UPC_W-1:0] s, input logic autoinc);
      ucode_t u;
      u = '0;
      case (s)
         2: u = xfer(RD_AGL, WR_MAR);
         3: u = xfer(RD_MEM, WR_DR);
         4: u.inc_dr = autoinc;
         5: if (autoinc) u = xfer(RD_DR, WR_MEM);
         default: u.iend = 1'b1;
      endcase
      return u;
   endfunction

   always_comb begin
      // Unused rows go straight back to fetch
      uinst      = '0;
      uinst.iend = 1'b1;
      if (step == 0) begin
         uinst = xfer(RD_PC, WR_MAR);
      end else if (step == 1) begin
         uinst        = xfer(RD_MEM, WR_IR);
         uinst.inc_pc = 1'b1;
      end else if (ind && step < 6 && op inside {OP_LOAD, OP_STOR, OP_JMP, OP_JSR}) begin
         uinst = ptr_row(step, ai);
      end else begin
         case (op)
            OP_TRAP: uinst.halt = 1'b1;
            OP_LOAD, OP_STOR: begin
               if (step == ea_step) begin
                  uinst = xfer(ea_src, WR_MAR);
               end else if (step == ea_step + 1'b1) begin
                  uinst = (op == OP_LOAD) ? xfer(RD_MEM, WR_A) : xfer(RD_A, WR_MEM);
                  uinst.iend = 1'b1;
               end
            end
            OP_JMP: begin
               if (step == ea_step) begin
                  uinst      = xfer(ea_src, WR_PC);
                  uinst.iend = 1'b1;
               end
            end
            OP_JSR: begin
               // Return PC to EA, then PC takes EA plus one
               case ({ind, step})
                  {1'b0, 4'd2}: uinst = xfer(RD_AGL, WR_MAR);
                  {1'b0, 4'd3}: uinst = xfer(RD_PC, WR_MEM);
                  {1'b0, 4'd4}: uinst = xfer(RD_MAR, WR_PC);
                  {1'b0, 4'd5}: uinst.inc_pc = 1'b1;
                  {1'b1, 4'd6}: begin
                     uinst        = xfer(RD_DR, WR_MAR);
                     uinst.inc_dr = 1'b1;
                  end
                  {1'b1, 4'd7}: uinst = xfer(RD_PC, WR_MEM);
                  {1'b1, 4'd8}: begin
                     uinst      = xfer(RD_DR, WR_PC);
                     uinst.iend = 1'b1;
                  end
                  default: ;
               endcase
            end
            OP_OP1: begin
               // skip carries IR bit 0, then bit 1, then the skip rule
               case (step)
                  2: begin
                     uinst          = xfer(RD_NONE, WR_NONE);
                     uinst.skip_ctl = SK_IRBIT0;
                  end
                  3: begin
                     uinst          = sk ? xfer(RD_ZERO, WR_A) : xfer(RD_NONE, WR_NONE);
                     uinst.skip_ctl = SK_IRBIT1;
                  end
                  4: begin
                     uinst       = xfer(RD_NONE, WR_NONE);
                     uinst.inc_a = sk;
                  end
                  5: begin
                     uinst          = xfer(RD_NONE, WR_NONE);
                     uinst.skip_ctl = SK_FLAGS;
                  end
                  6: uinst.inc_pc = sk;
                  default: ;
               endcase
            end
            default: ;
         endcase
      end
   end

endmodule

// ==== hdl/skip_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Skip unit: zero and negative flags of A, and the registered skip bit
// that feeds the microaddress on the following step.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cft_cpu_cfg.svh"

module skip_unit (
   input  logic                clock,
   input  logic                reset,
   input  cft_cpu_pkg::ucode_t uinst,
   input  cft_cpu_pkg::word_t  ir,
   input  cft_cpu_pkg::word_t  acc,
   output logic                skip
);
   import cft_cpu_pkg::*;

   logic flag_z;
   logic flag_n;

   // Flags straight off the accumulator
   assign flag_z = (acc == '0);
   assign flag_n = acc[`CFT_WORD_W-1];

   always_ff @(posedge clock) begin
      if (reset) begin
         skip <= 1'b0;
      end else begin
         case (uinst.skip_ctl)
            SK_IRBIT0: skip <= ir[0];
            SK_IRBIT1: skip <= ir[1];
            // OP1 rule, bit 2 on zero, bit 3 on negative
            SK_FLAGS:  skip <= (ir[2] & flag_z) | (ir[3] & flag_n);
            default:   skip <= skip;
         endcase
      end
   end

endmodule

// ==== hdl/unit_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Unit decoder: expands the read and write unit fields into one-hot
// selects for the datapath and the memory read and write strobes.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module unit_decoder (
   input  cft_cpu_pkg::ucode_t uinst,
   unit_sel_if.decoder         sel,
   output logic                mem_read,
   output logic                mem_write
);
   import cft_cpu_pkg::*;

   always_comb begin
      // Write side
      sel.w_mar  = (uinst.write_unit == WR_MAR);
      sel.w_pc   = (uinst.write_unit == WR_PC);
      sel.w_ir   = (uinst.write_unit == WR_IR);
      sel.w_dr   = (uinst.write_unit == WR_DR);
      sel.w_a    = (uinst.write_unit == WR_A);
      // Read side
      sel.r_agl  = (uinst.read_unit == RD_AGL);
      sel.r_pc   = (uinst.read_unit == RD_PC);
      sel.r_dr   = (uinst.read_unit == RD_DR);
      sel.r_a    = (uinst.read_unit == RD_A);
      sel.r_mar  = (uinst.read_unit == RD_MAR);
      sel.r_zero = (uinst.read_unit == RD_ZERO);
      sel.r_mem  = (uinst.read_unit == RD_MEM);
      // Increments pass straight through
      sel.inc_a  = uinst.inc_a;
      sel.inc_pc = uinst.inc_pc;
      sel.inc_dr = uinst.inc_dr;
      // Memory is a read source or a write sink
      mem_read   = (uinst.read_unit == RD_MEM);
      mem_write  = (uinst.write_unit == WR_MEM);
   end

   // No microinstruction moves memory to memory
   always_comb begin
      a_no_rw_strobe : assert (!(mem_read && mem_write))
         else $error("read and write strobes asserted together");
   end

endmodule

// ==== hdl/unit_sel_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Decoded unit selects between the unit decoder and the datapath.
// The decoder drives every line; the datapath only reads them.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface unit_sel_if;

   // Write selects, at most one high
   logic w_mar;
   logic w_pc;
   logic w_ir;
   logic w_dr;
   logic w_a;

   // Read selects, at most one high
   logic r_agl;
   logic r_pc;
   logic r_dr;
   logic r_a;
   logic r_mar;
   logic r_zero;
   logic r_mem;

   // Register increments
   logic inc_a;
   logic inc_pc;
   logic inc_dr;

   modport decoder (
      output w_mar, w_pc, w_ir, w_dr, w_a,
      output r_agl, r_pc, r_dr, r_a, r_mar, r_zero, r_mem,
      output inc_a, inc_pc, inc_dr
   );

   modport datapath (
      input w_mar, w_pc, w_ir, w_dr, w_a,
      input r_agl, r_pc, r_dr, r_a, r_mar, r_zero, r_mem,
      input inc_a, inc_pc, inc_dr
   );

endinterface
